// ==== pit_counter.f ====
+incdir+hw
hw/pit_pkg.sv
hw/pit_if.sv
hw/pit_control_decode.sv
hw/pit_count_execute.sv
hw/pit_out_result.sv
hw/pit_counter.sv
verif/pit_counter_checker.sv
verif/pit_counter_tb.sv

// ==== verif/pit_counter_tb.sv ====
/*
 * Testbench for pit_counter: clock, reset, bus tasks, mode 0/2/4,
 * gate, latch and LSB-only tests, per-test report and watchdog
 */

`timescale 1ns/1ps

module pit_counter_tb
    import pit_pkg::*;
();

    logic       clock;
    logic       reset;
    logic [7:0] data_bus;
    logic       write_control;
    logic       write_counter;
    logic       read_counter;
    logic       counter_clock;
    logic       counter_gate;
    logic [7:0] read_data;
    logic       counter_out;

    integer seed;
    int     counts [6];
    int     limit_cycles;
    int     test_errors;
    int     passed;
    int     failed;
    string  test_name;

    pit_counter u_pit_counter (
        .clock         (clock),
        .reset         (reset),
        .data_bus      (data_bus),
        .write_control (write_control),
        .write_counter (write_counter),
        .read_counter  (read_counter),
        .counter_clock (counter_clock),
        .counter_gate  (counter_gate),
        .read_data     (read_data),
        .counter_out   (counter_out)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    // One toggle every 4 clocks
    initial begin
        forever begin
            repeat (4) @(posedge clock);
            #1 counter_clock = ~counter_clock;
        end
    end

    task automatic bus_write(input logic control, input logic [7:0] value);
        @(posedge clock);
        #1;
        data_bus      = value;
        write_control = control;
        write_counter = !control;
        @(posedge clock);
        #1;
        write_control = 1'b0;
        write_counter = 1'b0;
    endtask

    // Writes finish well before the next falling edge, which loads the count
    task automatic setup_count(input logic [7:0] word, input int n);
        @(negedge counter_clock);
        bus_write(1'b1, word);
        bus_write(1'b0, n[7:0]);
        if (word[5:4] == 2'b11)
            bus_write(1'b0, n[15:8]);
    endtask

    task automatic read_byte(output logic [7:0] value);
        @(posedge clock);
        #1;
        read_counter = 1'b1;
        repeat (2) @(posedge clock);
        #1;
        value        = read_data;
        read_counter = 1'b0;
        repeat (2) @(posedge clock);
    endtask

    // counter_out settles 4 clocks after a falling edge
    task automatic wait_edges(input int n);
        if (n > 0) begin
            repeat (n) @(negedge counter_clock);
            repeat (6) @(posedge clock);
            #1;
        end
    endtask

    task automatic check_value(input int expected, input int actual);
        assert (actual == expected) else begin
            $display("Fail %s expected %0h actual %0h", test_name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic finish_test();
        if (test_errors == 0) begin
            passed++;
            $display("Test %s passed", test_name);
        end else begin
            failed++;
            $display("Test %s failed with %0d errors", test_name, test_errors);
        end
        test_errors = 0;
    endtask

    // Mode 0: low after the write, high after n+1 edges plus the gate hold
    task automatic run_mode0(input string name, input int n, input int hold,
                             input logic [7:0] word);
        test_name = name;
        setup_count(word, n);
        check_value(0, counter_out);
        wait_edges(1);
        counter_gate = (hold == 0);
        wait_edges(hold);
        counter_gate = 1'b1;
        wait_edges(n - 1);
        check_value(0, counter_out);
        wait_edges(1);
        check_value(1, counter_out);
        finish_test();
    endtask

    initial begin
        logic [7:0] lsb_byte;
        logic [7:0] msb_byte;
        int         total;

        reset         = 1'b1;
        data_bus      = '0;
        write_control = 1'b0;
        write_counter = 1'b0;
        read_counter  = 1'b0;
        counter_clock = 1'b0;
        counter_gate  = 1'b1;
        passed        = 0;
        failed        = 0;
        test_errors   = 0;
        seed          = 32'h7db;
        total         = 0;
        for (int i = 0; i < 6; i++) begin
            counts[i] = 2 + ({$random(seed)} % 19);
            total += (counts[i] + 4) * 8;
        end
        // Mode 2 spans two periods, so double it
        limit_cycles = 2 * total + 1000;

        fork
            begin
                repeat (limit_cycles) @(posedge clock);
                $display("Timeout: tests did not finish within %0d clocks", limit_cycles);
                $display("Result: FAILED");
                $finish;
            end
        join_none

        repeat (3) @(posedge clock);
        #1;
        reset = 1'b0;

        run_mode0("mode0_lsb_msb", counts[0], 0, 8'h30);
        run_mode0("mode0_gate", counts[1], 3, 8'h30);

        test_name = "mode2_rate";
        setup_count(8'h34, counts[2]);
        wait_edges(counts[2] - 1);
        check_value(1, counter_out);
        wait_edges(1);
        check_value(0, counter_out);
        wait_edges(1);
        check_value(1, counter_out);
        wait_edges(counts[2] - 2);
        check_value(1, counter_out);
        wait_edges(1);
        check_value(0, counter_out);
        wait_edges(1);
        check_value(1, counter_out);
        finish_test();

        test_name = "mode4_strobe";
        setup_count(8'h38, counts[3]);
        check_value(1, counter_out);
        wait_edges(counts[3]);
        check_value(1, counter_out);
        wait_edges(1);
        check_value(0, counter_out);
        wait_edges(1);
        check_value(1, counter_out);
        wait_edges(2);
        check_value(1, counter_out);
        finish_test();

        // Load edge plus two decrements, then latch and read across later edges
        test_name = "latch_read";
        setup_count(8'h30, counts[4]);
        wait_edges(3);
        bus_write(1'b1, 8'h00);
        // Next falling edge coincides with the end of the latch write
        @(posedge clock);
        wait_edges(2);
        read_byte(lsb_byte);
        wait_edges(2);
        read_byte(msb_byte);
        check_value(counts[4] - 2, {msb_byte, lsb_byte});
        finish_test();

        run_mode0("lsb_only", counts[5], 0, 8'h10);

        $display("Tests passed: %0d, failed: %0d, assertion failures: %0d",
                 passed, failed, u_pit_counter.u_checker.fail_count);
        if ((failed == 0) && (u_pit_counter.u_checker.fail_count == 0))
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

// ==== verif/pit_counter_checker.sv ====
/*
 * Concurrent assertions on the counter channel: reset state,
 * mode 2 low pulse width and read latch stability
 */

`timescale 1ns/1ps
`include "pit_cfg.svh"

module pit_counter_checker
    import pit_pkg::*;
(
    input logic      clock,
    input logic      reset,
    input logic      counter_out,
    input logic      count_edge,
    input pit_mode_e mode,
    input pit_rw_e   rw_select,
    input logic      config_write,
    input logic      latch_cmd,
    input logic      read_counter,
    input count_t    latch_value
);

    logic       low_at_edge;
    logic       read_prev;
    logic [1:0] reads_left;
    int         fail_count = 0;

    // counter_out level seen at the last count_edge in mode 2
    always_ff @(posedge clock) begin
        if (reset)
            low_at_edge <= 1'b0;
        else if (count_edge)
            low_at_edge <= (mode == mode_2) && !counter_out;
    end

    // Bytes still to be read from a latched count
    always_ff @(posedge clock) begin
        if (reset) begin
            read_prev  <= 1'b0;
            reads_left <= 2'd0;
        end else begin
            read_prev <= read_counter;
            if (config_write)
                reads_left <= 2'd0;
            else if (latch_cmd && (reads_left == 2'd0))
                reads_left <= (rw_select == rw_lsb_msb) ? 2'd2 : 2'd1;
            else if (read_prev && !read_counter && (reads_left != 2'd0))
                reads_left <= reads_left - 2'd1;
        end
    end

    property out_low_after_reset;
        @(posedge clock) reset |=> !counter_out;
    endproperty

    property mode2_single_low;
        @(posedge clock) disable iff (reset)
            (count_edge && (mode == mode_2) && low_at_edge) |-> counter_out;
    endproperty

    property latch_holds;
        @(posedge clock) disable iff (reset)
            ((reads_left != 2'd0) && ($past(reads_left) != 2'd0)) |-> $stable(latch_value);
    endproperty

    assert property (out_low_after_reset)
        else begin
            $error("counter_out is not low after reset");
            fail_count++;
        end
    assert property (mode2_single_low)
        else begin
            $error("counter_out low for two count edges in mode 2");
            fail_count++;
        end
    assert property (latch_holds)
        else begin
            $error("latched count changed before it was read");
            fail_count++;
        end

endmodule

bind pit_counter pit_counter_checker u_checker (
    .clock        (clock),
    .reset        (reset),
    .counter_out  (counter_out),
    .count_edge   (cnt_bus.count_edge),
    .mode         (cfg_bus.mode),
    .rw_select    (cfg_bus.rw_select),
    .config_write (cfg_bus.config_write),
    .latch_cmd    (cfg_bus.latch_cmd),
    .read_counter (read_counter),
    .latch_value  (u_out_result.latch_value)
);

// ==== hw/pit_counter.sv ====
/*
 * Interval timer counter channel, top level
 */

`timescale 1ns/1ps
`include "pit_cfg.svh"

module pit_counter (
    input  logic                   clock,
    input  logic                   reset,
    input  logic [`PIT_DATA_W-1:0] data_bus,
    input  logic                   write_control,
    input  logic                   write_counter,
    input  logic                   read_counter,
    input  logic                   counter_clock,
    input  logic                   counter_gate,
    output logic [`PIT_DATA_W-1:0] read_data,
    output logic                   counter_out
);

    pit_cfg_if   cfg_bus ();
    pit_count_if cnt_bus ();

    pit_control_decode u_control_decode (
        .clock         (clock),
        .reset         (reset),
        .data_bus      (data_bus),
        .write_control (write_control),
        .write_counter (write_counter),
        .cfg           (cfg_bus),
        .loaded        (cnt_bus.loaded)
    );

    pit_count_execute u_count_execute (
        .clock         (clock),
        .reset         (reset),
        .counter_clock (counter_clock),
        .counter_gate  (counter_gate),
        .cfg           (cfg_bus),
        .cnt           (cnt_bus)
    );

    pit_out_result u_out_result (
        .clock         (clock),
        .reset         (reset),
        .read_counter  (read_counter),
        .cfg           (cfg_bus),
        .cnt           (cnt_bus),
        .read_data     (read_data),
        .counter_out   (counter_out)
    );

endmodule

// ==== hw/pit_out_result.sv ====
/*
 * counter_out waveform per mode, read latch and read byte sequencing
 */

`timescale 1ns/1ps
`include "pit_cfg.svh"

module pit_out_result
    import pit_pkg::*;
(
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   read_counter,
    pit_cfg_if.sink                cfg,
    pit_count_if.sink              cnt,
    output logic [`PIT_DATA_W-1:0] read_data,
    output logic                   counter_out
);

    logic   read_prev;
    logic   read_fall;
    logic   read_msb_next;
    logic   last_byte;
    logic   latched;
    logic   edge_q;
    logic   load_q;
    logic   term_prev;
    count_t latch_value;

    // Count is settled one clock after count_edge
    always_ff @(posedge clock) begin
        if (reset) begin
            edge_q    <= 1'b0;
            load_q    <= 1'b0;
            term_prev <= 1'b0;
        end else begin
            edge_q <= cnt.count_edge;
            load_q <= cnt.loaded;
            if (edge_q)
                term_prev <= cnt.terminal;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            counter_out <= 1'b0;
        end else begin
            case (cfg.mode)
                mode_0: begin
                    if (!cfg.armed || cfg.load_req)
                        counter_out <= 1'b0;
                    else if (edge_q && cnt.terminal && !load_q)
                        counter_out <= 1'b1;
                end
                mode_2: begin
                    // Low only while the count sits at 1
                    if (!cfg.armed)
                        counter_out <= 1'b1;
                    else if (edge_q)
                        counter_out <= (cnt.count != count_t'(1));
                end
                mode_4: begin
                    if (!cfg.armed || cfg.load_req)
                        counter_out <= 1'b1;
                    else if (edge_q)
                        counter_out <= !(cnt.terminal && !term_prev && !load_q);
                end
                default: counter_out <= counter_out;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (reset)
            read_prev <= 1'b0;
        else
            read_prev <= read_counter;
    end

    always_comb begin
        read_fall = read_prev & ~read_counter;
        last_byte = (cfg.rw_select != rw_lsb_msb) || read_msb_next;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            read_msb_next <= 1'b0;
        end else if (cfg.config_write) begin
            read_msb_next <= (cfg.rw_select == rw_msb);
        end else if (read_fall && (cfg.rw_select == rw_lsb_msb)) begin
            read_msb_next <= ~read_msb_next;
        end
    end

    // Further latch commands are ignored until the latch is read out
    always_ff @(posedge clock) begin
        if (reset)
            latched <= 1'b0;
        else if (cfg.config_write)
            latched <= 1'b0;
        else if (cfg.latch_cmd && !latched)
            latched <= 1'b1;
        else if (read_fall && last_byte)
            latched <= 1'b0;
    end

    always_ff @(posedge clock) begin
        if (!latched)
            latch_value <= cnt.count;
    end

    always_ff @(posedge clock) begin
        if (reset)
            read_data <= '0;
        else if (read_msb_next)
            read_data <= latch_value[`PIT_DATA_W +: `PIT_DATA_W];
        else
            read_data <= latch_value[0 +: `PIT_DATA_W];
    end

endmodule

// ==== hw/pit_count_execute.sv ====
/*
 * Count engine: counter_clock and counter_gate sampling,
 * falling edge detect, preset load and binary down count
 */

`timescale 1ns/1ps
`include "pit_cfg.svh"

module pit_count_execute
    import pit_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    input  logic        counter_clock,
    input  logic        counter_gate,
    pit_cfg_if.sink     cfg,
    pit_count_if.source cnt
);

    logic   clk_sync;
    logic   clk_prev;
    logic   gate_sync;
    logic   edge_q;
    logic   active;
    logic   load_now;
    count_t count_q;
    count_t count_next;

    // One synchronizer stage for the external pins
    always_ff @(posedge clock) begin
        if (reset) begin
            clk_sync  <= 1'b0;
            gate_sync <= 1'b0;
        end else begin
            clk_sync  <= counter_clock;
            gate_sync <= counter_gate;
        end
    end

    // Registered falling edge of counter_clock
    always_ff @(posedge clock) begin
        if (reset) begin
            clk_prev <= 1'b0;
            edge_q   <= 1'b0;
        end else begin
            clk_prev <= clk_sync;
            edge_q   <= clk_prev & ~clk_sync;
        end
    end

    always_comb begin
        active   = (cfg.mode != mode_other);
        load_now = edge_q && cfg.load_req && active;
    end

    always_comb begin
        count_next = count_q;
        if (load_now) begin
            count_next = cfg.preset;
        end else if (edge_q && gate_sync && active) begin
            // Mode 2 reloads instead of reaching zero
            if ((cfg.mode == mode_2) && (count_q == count_t'(1)))
                count_next = cfg.preset;
            else
                count_next = count_q - count_t'(1);
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            count_q <= `PIT_COUNT_ZERO;
        end else if (!cfg.armed) begin
            count_q <= `PIT_COUNT_ZERO;
        end else begin
            count_q <= count_next;
        end
    end

    assign cnt.count      = count_q;
    assign cnt.count_edge = edge_q;
    assign cnt.loaded     = load_now;
    assign cnt.terminal   = (count_q == `PIT_COUNT_ZERO);

endmodule

// ==== hw/pit_control_decode.sv ====
/*
 * Control word and count write decoder
 * Holds mode, read/load format, write byte step and preset
 */

`timescale 1ns/1ps
`include "pit_cfg.svh"

module pit_control_decode
    import pit_pkg::*;
(
    input  logic                   clock,
    input  logic                   reset,
    input  logic [`PIT_DATA_W-1:0] data_bus,
    input  logic                   write_control,
    input  logic                   write_counter,
    pit_cfg_if.source              cfg,
    input  logic                   loaded
);

    pit_rw_e   ctrl_rw;
    pit_mode_e ctrl_mode;
    logic      take_config;
    logic      take_latch;
    logic      write_msb_next;
    logic      count_done;

    // 110 is still mode 2, 111 is mode 3
    function automatic pit_mode_e decode_mode(input logic [`PIT_MODE_W-1:0] field);
        pit_mode_e m;
        casez (field)
            3'b000:  m = mode_0;
            3'b?10:  m = mode_2;
            3'b100:  m = mode_4;
            default: m = mode_other;
        endcase
        return m;
    endfunction

    always_comb begin
        ctrl_rw     = pit_rw_e'(data_bus[`PIT_RW_LSB +: `PIT_RW_W]);
        ctrl_mode   = decode_mode(data_bus[`PIT_MODE_LSB +: `PIT_MODE_W]);
        take_latch  = write_control && (ctrl_rw == rw_latch);
        take_config = write_control && (ctrl_rw != rw_latch);
        // Last byte of the count for the current format
        count_done  = write_counter &&
                      ((cfg.rw_select != rw_lsb_msb) || write_msb_next);
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            cfg.mode      <= mode_0;
            cfg.rw_select <= rw_lsb_msb;
        end else if (take_config) begin
            cfg.mode      <= ctrl_mode;
            cfg.rw_select <= ctrl_rw;
        end
    end

    // One-cycle command pulses
    always_ff @(posedge clock) begin
        if (reset) begin
            cfg.config_write <= 1'b0;
            cfg.latch_cmd    <= 1'b0;
        end else begin
            cfg.config_write <= take_config;
            cfg.latch_cmd    <= take_latch;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            write_msb_next <= 1'b0;
        end else if (take_config) begin
            write_msb_next <= (ctrl_rw == rw_msb);
        end else if (write_counter && (cfg.rw_select == rw_lsb_msb)) begin
            write_msb_next <= ~write_msb_next;
        end
    end

    // Single-byte formats clear the other half
    always_ff @(posedge clock) begin
        if (write_counter) begin
            case (cfg.rw_select)
                rw_lsb: cfg.preset <= {{`PIT_DATA_W{1'b0}}, data_bus};
                rw_msb: cfg.preset <= {data_bus, {`PIT_DATA_W{1'b0}}};
                default: begin
                    if (write_msb_next)
                        cfg.preset[`PIT_DATA_W +: `PIT_DATA_W] <= data_bus;
                    else
                        cfg.preset[0 +: `PIT_DATA_W] <= data_bus;
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            cfg.load_req <= 1'b0;
            cfg.armed    <= 1'b0;
        end else if (take_config) begin
            cfg.load_req <= 1'b0;
            cfg.armed    <= 1'b0;
        end else if (count_done) begin
            cfg.armed <= 1'b1;
            // Mode 2 picks up a new preset at the next reload
            if (!((cfg.mode == mode_2) && cfg.armed))
                cfg.load_req <= 1'b1;
        end else if (loaded) begin
            cfg.load_req <= 1'b0;
        end
    end

endmodule

// ==== hw/pit_if.sv ====
/*
 * pit_cfg_if: configuration and load requests from the control decoder
 * pit_count_if: count state from the count engine
 */

`timescale 1ns/1ps

interface pit_cfg_if import pit_pkg::*; ();
    pit_mode_e mode;
    pit_rw_e   rw_select;
    count_t    preset;
    logic      config_write;
    logic      latch_cmd;
    logic      load_req;
    logic      armed;

    modport source (
        output mode, rw_select, preset, config_write, latch_cmd, load_req, armed
    );

    modport sink (
        input  mode, rw_select, preset, config_write, latch_cmd, load_req, armed
    );
endinterface

interface pit_count_if import pit_pkg::*; ();
    count_t count;
    logic   count_edge;
    logic   loaded;
    logic   terminal;

    modport source (
        output count, count_edge, loaded, terminal
    );

    modport sink (
        input  count, count_edge, loaded, terminal
    );
endinterface

// ==== hw/pit_pkg.sv ====
/*
 * Mode and read/load enums, count type
 */

`include "pit_cfg.svh"

package pit_pkg;

    // Modes 1, 3 and 5 all land on mode_other
    typedef enum logic [`PIT_MODE_W-1:0] {
        mode_0     = 3'd0,
        mode_2     = 3'd2,
        mode_4     = 3'd4,
        mode_other = 3'd7
    } pit_mode_e;

    // RL field of the control word
    typedef enum logic [`PIT_RW_W-1:0] {
        rw_latch   = 2'b00,
        rw_lsb     = 2'b01,
        rw_msb     = 2'b10,
        rw_lsb_msb = 2'b11
    } pit_rw_e;

    typedef logic [`PIT_COUNT_W-1:0] count_t;

endpackage

// ==== hw/pit_cfg.svh ====
/*
 * Bus and count widths, control word field positions, zero count
 */

`ifndef PIT_CFG_SVH
`define PIT_CFG_SVH

// Bus byte and count widths
`define PIT_DATA_W      8
`define PIT_COUNT_W     16

// Control word fields
`define PIT_RW_LSB      4
`define PIT_RW_W        2
`define PIT_MODE_LSB    1
`define PIT_MODE_W      3

// Loaded as zero, counts as 65536
`define PIT_COUNT_ZERO  {`PIT_COUNT_W{1'b0}}

`endif
